/* Bender.yml */
package:
  name: agc_mem_map

sources:
  - files:
      - rtl/agc_mem_pkg.sv
      - rtl/agc_cmd_pkg.sv
      - rtl/cmd_intake.sv
      - rtl/cmd_fifo.sv
      - rtl/bank_regs.sv
      - rtl/bank_translate.sv
      - rtl/addr_resolver.sv
      - rtl/agc_mem_map.sv
  - target: test
    files:
      - dv/tb_agc_mem_map.sv

/* agc_mem_map.f */
rtl/agc_mem_pkg.sv
rtl/agc_cmd_pkg.sv
rtl/cmd_intake.sv
rtl/cmd_fifo.sv
rtl/bank_regs.sv
rtl/bank_translate.sv
rtl/addr_resolver.sv
rtl/agc_mem_map.sv
dv/tb_agc_mem_map.sv

/* dv/agc_mem_map_stimulus.txt */
# op addr data region rom_addr ram_addr write_ok bank_word, every column in octal
# op 0 read 1 write 2 set_eb 3 set_fb 4 set_bb, region 0 RAM 1 ROM
0 0000 00000 0 00000 0000 0 00000
0 0123 00000 0 00000 0123 0 00000
0 1377 00000 0 00000 1377 0 00000
0 4000 00000 1 00000 0000 0 00000
0 7777 00000 1 03777 0000 0 00000
0 5432 00000 1 01432 0000 0 00000
0 1400 00000 0 00000 1400 0 00000
0 2000 00000 1 04000 0000 0 00000
2 0000 72345 0 00000 0000 0 02000
0 1400 00000 0 00000 2400 0 00000
0 1777 00000 0 00000 2777 0 00000
3 0000 35555 0 00000 0000 0 30000
0 2000 00000 1 12000 0000 0 00000
0 3777 00000 1 13777 0000 0 00000
1 0100 12345 0 00000 0100 1 00000
1 4567 00000 1 00567 0000 0 00000
1 2345 77777 1 12345 0000 0 00000
1 1500 00001 0 00000 2500 1 00000
4 0000 75000 0 00000 0000 0 75000
0 1400 00000 0 00000 3400 0 00000
0 1777 00000 0 00000 3777 0 00000
0 2000 00000 1 22000 0000 0 00000
0 3777 00000 1 23777 0000 0 00000
0 1600 00000 0 00000 3600 0 00000
2 0000 03000 0 00000 0000 0 03000
0 1600 00000 0 00000 3200 0 00000
3 0000 04444 0 00000 0000 0 00000
0 3000 00000 1 05000 0000 0 00000
1 1777 00000 0 00000 3377 1 00000
0 0777 00000 0 00000 0777 0 00000
4 0000 00000 0 00000 0000 0 00000
0 1401 00000 0 00000 1401 0 00000
0 2001 00000 1 04001 0000 0 00000

/* dv/tb_agc_mem_map.sv */
`timescale 1ns/1ps

module tb_agc_mem_map;

  localparam int FIFO_DEPTH = 4;
  localparam int CLK_PERIOD = 40;
  localparam int WAIT_LIMIT = 200;

  logic                     clk;
  logic                     rst_l;
  logic                     cmd_req;
  agc_cmd_pkg::cmd_op_t     cmd_op;
  agc_mem_pkg::soft_addr_t  cmd_addr;
  agc_mem_pkg::word_t       cmd_data;
  logic                     cmd_ack;
  logic                     rsp_req;
  agc_cmd_pkg::mem_region_t rsp_region;
  agc_mem_pkg::rom_addr_t   rsp_rom_addr;
  agc_mem_pkg::ram_addr_t   rsp_ram_addr;
  logic                     rsp_write_ok;
  agc_mem_pkg::word_t       rsp_bank_word;
  logic                     rsp_ack;

  // Commands and expected results as read from the stimulus file
  agc_cmd_pkg::cmd_op_t     stim_op[$];
  agc_mem_pkg::soft_addr_t  stim_addr[$];
  agc_mem_pkg::word_t       stim_data[$];
  agc_cmd_pkg::mem_region_t stim_region[$];
  agc_mem_pkg::rom_addr_t   stim_rom[$];
  agc_mem_pkg::ram_addr_t   stim_ram[$];
  logic                     stim_wok[$];
  agc_mem_pkg::word_t       stim_bank[$];

  // Results still owed by the DUT in issue order
  int                       exp_index_q[$];
  agc_cmd_pkg::mem_region_t exp_region_q[$];
  agc_mem_pkg::rom_addr_t   exp_rom_q[$];
  agc_mem_pkg::ram_addr_t   exp_ram_q[$];
  logic                     exp_wok_q[$];
  agc_mem_pkg::word_t       exp_bank_q[$];

  logic [31:0] rng_state;
  int          max_outstanding;

  agc_mem_map #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk           (clk),
    .rst_l         (rst_l),
    .cmd_req       (cmd_req),
    .cmd_op        (cmd_op),
    .cmd_addr      (cmd_addr),
    .cmd_data      (cmd_data),
    .cmd_ack       (cmd_ack),
    .rsp_req       (rsp_req),
    .rsp_region    (rsp_region),
    .rsp_rom_addr  (rsp_rom_addr),
    .rsp_ram_addr  (rsp_ram_addr),
    .rsp_write_ok  (rsp_write_ok),
    .rsp_bank_word (rsp_bank_word),
    .rsp_ack       (rsp_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_region(input string name, input agc_cmd_pkg::mem_region_t exp,
                              input agc_cmd_pkg::mem_region_t act);
    if (act !== exp) abort_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_rom_addr(input string name, input agc_mem_pkg::rom_addr_t exp,
                                input agc_mem_pkg::rom_addr_t act);
    if (act !== exp) abort_run($sformatf("error %s: expected %o, actual %o", name, exp, act));
  endtask

  task automatic check_ram_addr(input string name, input agc_mem_pkg::ram_addr_t exp,
                                input agc_mem_pkg::ram_addr_t act);
    if (act !== exp) abort_run($sformatf("error %s: expected %o, actual %o", name, exp, act));
  endtask

  task automatic check_word(input string name, input agc_mem_pkg::word_t exp,
                            input agc_mem_pkg::word_t act);
    if (act !== exp) abort_run($sformatf("error %s: expected %o, actual %o", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
  endtask

  // Plain 32-bit LCG
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Lines starting with # are column notes
  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    int    op_v, addr_v, data_v, reg_v, rom_v, ram_v, wok_v, bank_v;
    fd = $fopen("dv/agc_mem_map_stimulus.txt", "r");
    if (fd == 0) abort_run("could not open the stimulus file");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%o %o %o %o %o %o %o %o",
                  op_v, addr_v, data_v, reg_v, rom_v, ram_v, wok_v, bank_v);
      if (n <= 0) continue;
      if (n != 8) abort_run($sformatf("malformed stimulus line: %s", line));
      stim_op.push_back(agc_cmd_pkg::cmd_op_t'(op_v[2:0]));
      stim_addr.push_back(agc_mem_pkg::soft_addr_t'(addr_v));
      stim_data.push_back(agc_mem_pkg::word_t'(data_v));
      stim_region.push_back(agc_cmd_pkg::mem_region_t'(reg_v[0]));
      stim_rom.push_back(agc_mem_pkg::rom_addr_t'(rom_v));
      stim_ram.push_back(agc_mem_pkg::ram_addr_t'(ram_v));
      stim_wok.push_back(wok_v[0]);
      stim_bank.push_back(agc_mem_pkg::word_t'(bank_v));
    end
    $fclose(fd);
    if (stim_op.size() == 0) abort_run("stimulus file holds no commands");
  endtask

  // Sampled on falling edges away from the drive edge
  task automatic wait_cmd_ack(input logic level, input int idx);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (cmd_ack !== level) begin
      if (cycles >= WAIT_LIMIT) begin
        abort_run($sformatf("timeout waiting for cmd_ack to go %b on command %0d", level, idx));
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic wait_rsp_req(input logic level, input int idx);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (rsp_req !== level) begin
      if (cycles >= WAIT_LIMIT) begin
        abort_run($sformatf("timeout waiting for rsp_req to go %b on result %0d", level, idx));
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // Sender side of the command link
  task automatic drive_commands();
    int i;
    for (i = 0; i < stim_op.size(); i++) begin
      wait_cmd_ack(1'b0, i);
      exp_index_q.push_back(i);
      exp_region_q.push_back(stim_region[i]);
      exp_rom_q.push_back(stim_rom[i]);
      exp_ram_q.push_back(stim_ram[i]);
      exp_wok_q.push_back(stim_wok[i]);
      exp_bank_q.push_back(stim_bank[i]);
      @(posedge clk);
      // Responder only pops on falling edges
      if (exp_index_q.size() > max_outstanding) max_outstanding = exp_index_q.size();
      cmd_req  <= 1'b1;
      cmd_op   <= stim_op[i];
      cmd_addr <= stim_addr[i];
      cmd_data <= stim_data[i];
      wait_cmd_ack(1'b1, i);
      @(posedge clk);
      cmd_req <= 1'b0;
    end
  endtask

  // Receiver side of the response link with a random ack delay
  task automatic answer_responses();
    int    n;
    int    idx;
    int    delay;
    string name;
    for (n = 0; n < stim_op.size(); n++) begin
      wait_rsp_req(1'b1, n);
      if (exp_index_q.size() == 0) abort_run("response arrived with no command outstanding");
      idx  = exp_index_q.pop_front();
      name = $sformatf("cmd %0d", idx);
      check_region({name, " region"}, exp_region_q.pop_front(), rsp_region);
      check_rom_addr({name, " rom_addr"}, exp_rom_q.pop_front(), rsp_rom_addr);
      check_ram_addr({name, " ram_addr"}, exp_ram_q.pop_front(), rsp_ram_addr);
      check_flag({name, " write_ok"}, exp_wok_q.pop_front(), rsp_write_ok);
      check_word({name, " bank_word"}, exp_bank_q.pop_front(), rsp_bank_word);
      rng_state = lcg_next(rng_state);
      delay = (rng_state >> 16) % 13;
      repeat (delay) @(posedge clk);
      @(posedge clk);
      rsp_ack <= 1'b1;
      wait_rsp_req(1'b0, n);
      @(posedge clk);
      rsp_ack <= 1'b0;
    end
  endtask

  initial begin
    rst_l           = 1'b0;
    cmd_req         = 1'b0;
    cmd_op          = agc_cmd_pkg::OP_READ;
    cmd_addr        = '0;
    cmd_data        = '0;
    rsp_ack         = 1'b0;
    rng_state       = 32'h82152bfa;
    max_outstanding = 0;
    load_stimulus();
    repeat (4) @(posedge clk);
    rst_l <= 1'b1;
    @(negedge clk);
    check_flag("reset cmd_ack", 1'b0, cmd_ack);
    check_flag("reset rsp_req", 1'b0, rsp_req);
    fork
      drive_commands();
      answer_responses();
    join
    // No stray result after the last one
    repeat (10) begin
      @(negedge clk);
      check_flag("idle rsp_req", 1'b0, rsp_req);
    end
    if (max_outstanding <= FIFO_DEPTH) begin
      abort_run("command FIFO never came close to full");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

/* rtl/addr_resolver.sv */
`timescale 1ns/1ps

module addr_resolver (
  input  logic                          clk,
  input  logic                          rst_l,
  input  logic [agc_cmd_pkg::CMD_W-1:0] pop_data,
  input  logic                          empty,
  input  logic                          rsp_ack,
  output logic                          pop,
  output logic                          rsp_req,
  output agc_cmd_pkg::mem_region_t      rsp_region,
  output agc_mem_pkg::rom_addr_t        rsp_rom_addr,
  output agc_mem_pkg::ram_addr_t        rsp_ram_addr,
  output logic                          rsp_write_ok,
  output agc_mem_pkg::word_t            rsp_bank_word
);

  localparam int DATA_W = $bits(agc_mem_pkg::word_t);
  localparam int ADDR_W = $bits(agc_mem_pkg::soft_addr_t);
  localparam int OP_W   = $bits(agc_cmd_pkg::cmd_op_t);

  agc_cmd_pkg::resolve_state_t state, state_nxt;
  agc_cmd_pkg::cmd_op_t        cmd_op;
  agc_mem_pkg::soft_addr_t     cmd_addr;
  agc_mem_pkg::word_t          cmd_data;
  agc_mem_pkg::bank_t          eb;
  agc_mem_pkg::bank_t          fb;
  agc_mem_pkg::word_t          bank_word;
  agc_cmd_pkg::mem_region_t    region;
  agc_mem_pkg::rom_addr_t      rom_addr;
  agc_mem_pkg::ram_addr_t      ram_addr;

  // Unpack head entry {op, addr, data}
  assign cmd_op   = agc_cmd_pkg::cmd_op_t'(pop_data[agc_cmd_pkg::CMD_W-1 -: OP_W]);
  assign cmd_addr = pop_data[DATA_W +: ADDR_W];
  assign cmd_data = pop_data[DATA_W-1:0];

  // One command in flight at a time
  assign pop     = (state == agc_cmd_pkg::RS_IDLE) && !empty;
  assign rsp_req = (state == agc_cmd_pkg::RS_REQ);

  // Bank ops only land on the pop edge
  bank_regs u_bank_regs (
    .clk       (clk),
    .rst_l     (rst_l),
    .wr_en     (pop),
    .op        (cmd_op),
    .wr_data   (cmd_data),
    .eb        (eb),
    .fb        (fb),
    .bank_word (bank_word)
  );

  // Sees the banks as they stood before this command
  bank_translate u_bank_translate (
    .addr     (cmd_addr),
    .eb       (eb),
    .fb       (fb),
    .region   (region),
    .rom_addr (rom_addr),
    .ram_addr (ram_addr)
  );

  always_comb begin
    state_nxt = state;
    case (state)
      agc_cmd_pkg::RS_IDLE:     if (pop) state_nxt = agc_cmd_pkg::RS_REQ;
      agc_cmd_pkg::RS_REQ:      if (rsp_ack) state_nxt = agc_cmd_pkg::RS_WAIT_LOW;
      agc_cmd_pkg::RS_WAIT_LOW: if (!rsp_ack) state_nxt = agc_cmd_pkg::RS_IDLE;
      default:                  state_nxt = agc_cmd_pkg::RS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      state <= agc_cmd_pkg::RS_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Result fields held stable for the whole response handshake
  // ROM writes are suppressed but still report their translation
  always_ff @(posedge clk) begin
    if (pop) begin
      rsp_region    <= region;
      rsp_rom_addr  <= rom_addr;
      rsp_ram_addr  <= ram_addr;
      rsp_write_ok  <= (cmd_op == agc_cmd_pkg::OP_WRITE) && (region == agc_cmd_pkg::REGION_RAM);
      rsp_bank_word <= bank_word;
    end
  end

endmodule

/* rtl/agc_cmd_pkg.sv */
package agc_cmd_pkg;

  // Command opcodes carried on the command link
  typedef enum logic [2:0] {
    OP_READ   = 3'd0,
    OP_WRITE  = 3'd1,
    OP_SET_EB = 3'd2,
    OP_SET_FB = 3'd3,
    OP_SET_BB = 3'd4
  } cmd_op_t;

  // Which physical memory an address lands in
  typedef enum logic {
    REGION_RAM = 1'b0,
    REGION_ROM = 1'b1
  } mem_region_t;

  // Command intake FSM
  typedef enum logic [1:0] {
    IN_IDLE     = 2'd0,
    IN_ACK      = 2'd1,
    IN_WAIT_LOW = 2'd2
  } intake_state_t;

  // Resolver FSM
  typedef enum logic [1:0] {
    RS_IDLE     = 2'd0,
    RS_REQ      = 2'd1,
    RS_WAIT_LOW = 2'd2
  } resolve_state_t;

  // FIFO entry is {op, addr, data}
  localparam int CMD_W = $bits(cmd_op_t) + $bits(agc_mem_pkg::soft_addr_t)
                       + $bits(agc_mem_pkg::word_t);

endpackage

/* rtl/agc_mem_map.sv */
`timescale 1ns/1ps

module agc_mem_map #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     rst_l,
  // Command link
  input  logic                     cmd_req,
  input  agc_cmd_pkg::cmd_op_t     cmd_op,
  input  agc_mem_pkg::soft_addr_t  cmd_addr,
  input  agc_mem_pkg::word_t       cmd_data,
  output logic                     cmd_ack,
  // Response link
  output logic                     rsp_req,
  output agc_cmd_pkg::mem_region_t rsp_region,
  output agc_mem_pkg::rom_addr_t   rsp_rom_addr,
  output agc_mem_pkg::ram_addr_t   rsp_ram_addr,
  output logic                     rsp_write_ok,
  output agc_mem_pkg::word_t       rsp_bank_word,
  input  logic                     rsp_ack
);

  logic                          push;
  logic [agc_cmd_pkg::CMD_W-1:0] push_data;
  logic                          full;
  logic                          pop;
  logic [agc_cmd_pkg::CMD_W-1:0] pop_data;
  logic                          empty;

  cmd_intake u_cmd_intake (
    .clk       (clk),
    .rst_l     (rst_l),
    .cmd_req   (cmd_req),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .full      (full),
    .cmd_ack   (cmd_ack),
    .push      (push),
    .push_data (push_data)
  );

  // Decouples intake from a slow response side
  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk       (clk),
    .rst_l     (rst_l),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

  addr_resolver u_addr_resolver (
    .clk           (clk),
    .rst_l         (rst_l),
    .pop_data      (pop_data),
    .empty         (empty),
    .rsp_ack       (rsp_ack),
    .pop           (pop),
    .rsp_req       (rsp_req),
    .rsp_region    (rsp_region),
    .rsp_rom_addr  (rsp_rom_addr),
    .rsp_ram_addr  (rsp_ram_addr),
    .rsp_write_ok  (rsp_write_ok),
    .rsp_bank_word (rsp_bank_word)
  );

endmodule

/* rtl/agc_mem_pkg.sv */
package agc_mem_pkg;

  // One 15-bit machine word
  typedef logic [14:0] word_t;

  // Address as seen by software
  typedef logic [11:0] soft_addr_t;

  // Physical fixed-memory address
  typedef logic [13:0] rom_addr_t;

  // Physical erasable-memory address
  typedef logic [10:0] ram_addr_t;

  // Bank number for both EB and FB
  typedef logic [2:0]  bank_t;

  // Region bounds in software address space
  localparam soft_addr_t ROM_BASE       = 12'o2000;
  localparam soft_addr_t FIXED_ROM_BASE = 12'o4000;
  localparam soft_addr_t FIXED_RAM_TOP  = 12'o1400;

  // Bank sizes
  localparam rom_addr_t ROM_BANK_SIZE = 14'o2000;
  localparam ram_addr_t RAM_BANK_SIZE = 11'o400;

  // EB bit 2 selects the upper half of erasable memory
  localparam ram_addr_t RAM_HIGH_OFFSET = 11'o2000;

  // Bank field placement inside a word
  localparam int EB_LSB = 9;
  localparam int FB_LSB = 12;

endpackage

/* rtl/bank_regs.sv */
`timescale 1ns/1ps

module bank_regs (
  input  logic                 clk,
  input  logic                 rst_l,
  input  logic                 wr_en,
  input  agc_cmd_pkg::cmd_op_t op,
  input  agc_mem_pkg::word_t   wr_data,
  output agc_mem_pkg::bank_t   eb,
  output agc_mem_pkg::bank_t   fb,
  output agc_mem_pkg::word_t   bank_word
);

  localparam int BANK_W = $bits(agc_mem_pkg::bank_t);

  agc_mem_pkg::bank_t eb_nxt;
  agc_mem_pkg::bank_t fb_nxt;
  logic               load_eb;
  logic               load_fb;

  // BB view writes both fields at once
  assign load_eb = wr_en && (op == agc_cmd_pkg::OP_SET_EB || op == agc_cmd_pkg::OP_SET_BB);
  assign load_fb = wr_en && (op == agc_cmd_pkg::OP_SET_FB || op == agc_cmd_pkg::OP_SET_BB);

  // Only the bank field bits are taken from the data word
  assign eb_nxt = load_eb ? wr_data[agc_mem_pkg::EB_LSB +: BANK_W] : eb;
  assign fb_nxt = load_fb ? wr_data[agc_mem_pkg::FB_LSB +: BANK_W] : fb;

  // Readback of the addressed view, showing the value after this write
  always_comb begin
    bank_word = '0;
    case (op)
      agc_cmd_pkg::OP_SET_EB: bank_word[agc_mem_pkg::EB_LSB +: BANK_W] = eb_nxt;
      agc_cmd_pkg::OP_SET_FB: bank_word[agc_mem_pkg::FB_LSB +: BANK_W] = fb_nxt;
      agc_cmd_pkg::OP_SET_BB: begin
        bank_word[agc_mem_pkg::EB_LSB +: BANK_W] = eb_nxt;
        bank_word[agc_mem_pkg::FB_LSB +: BANK_W] = fb_nxt;
      end
      default: bank_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      eb <= '0;
      fb <= '0;
    end else begin
      eb <= eb_nxt;
      fb <= fb_nxt;
    end
  end

endmodule

/* rtl/bank_translate.sv */
`timescale 1ns/1ps

module bank_translate (
  input  agc_mem_pkg::soft_addr_t   addr,
  input  agc_mem_pkg::bank_t        eb,
  input  agc_mem_pkg::bank_t        fb,
  output agc_cmd_pkg::mem_region_t  region,
  output agc_mem_pkg::rom_addr_t    rom_addr,
  output agc_mem_pkg::ram_addr_t    ram_addr
);

  logic                   is_rom;
  logic                   ram_fixed;
  logic                   rom_fixed;
  agc_mem_pkg::ram_addr_t ram_offset;
  agc_mem_pkg::ram_addr_t ram_xlat;
  agc_mem_pkg::rom_addr_t rom_xlat;

  always_comb begin
    // Software space splits at octal 2000 into RAM below and ROM above
    is_rom    = (addr >= agc_mem_pkg::ROM_BASE);
    ram_fixed = (addr < agc_mem_pkg::FIXED_RAM_TOP);
    rom_fixed = (addr >= agc_mem_pkg::FIXED_ROM_BASE);

    // Erasable bank offset, EB bit 2 overrides the low two bits
    if (eb[2]) begin
      ram_offset = agc_mem_pkg::RAM_HIGH_OFFSET;
    end else begin
      ram_offset = agc_mem_pkg::ram_addr_t'(eb[1:0]) * agc_mem_pkg::RAM_BANK_SIZE;
    end

    // Banked RAM wraps modulo 2^11
    if (ram_fixed) begin
      ram_xlat = addr[10:0];
    end else begin
      ram_xlat = addr[10:0] + ram_offset;
    end

    // Fixed-fixed ROM starts at physical zero
    // Banked window skips one bank, then steps by FB
    if (rom_fixed) begin
      rom_xlat = agc_mem_pkg::rom_addr_t'(addr - agc_mem_pkg::FIXED_ROM_BASE);
    end else begin
      rom_xlat = agc_mem_pkg::rom_addr_t'(addr) + agc_mem_pkg::ROM_BANK_SIZE
               + agc_mem_pkg::rom_addr_t'(fb) * agc_mem_pkg::ROM_BANK_SIZE;
    end

    // Unselected side reads as zero
    region   = is_rom ? agc_cmd_pkg::REGION_ROM : agc_cmd_pkg::REGION_RAM;
    rom_addr = is_rom ? rom_xlat : '0;
    ram_addr = is_rom ? '0 : ram_xlat;
  end

endmodule

/* rtl/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_l,
  input  logic                          push,
  input  logic [agc_cmd_pkg::CMD_W-1:0] push_data,
  input  logic                          pop,
  output logic [agc_cmd_pkg::CMD_W-1:0] pop_data,
  output logic                          full,
  output logic                          empty
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [agc_cmd_pkg::CMD_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]              wr_ptr;
  logic [PTR_W-1:0]              rd_ptr;
  // One extra bit so a full buffer is distinct from empty
  logic [PTR_W:0]                count;
  logic                          do_push;
  logic                          do_pop;

  assign full  = (count == (PTR_W+1)'(FIFO_DEPTH));
  assign empty = (count == '0);

  // Qualify against flags so a stray request cannot corrupt pointers
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Show-ahead head entry
  assign pop_data = mem[rd_ptr];

  // Storage array
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves occupancy unchanged
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/cmd_intake.sv */
`timescale 1ns/1ps

module cmd_intake (
  input  logic                          clk,
  input  logic                          rst_l,
  input  logic                          cmd_req,
  input  agc_cmd_pkg::cmd_op_t          cmd_op,
  input  agc_mem_pkg::soft_addr_t       cmd_addr,
  input  agc_mem_pkg::word_t            cmd_data,
  input  logic                          full,
  output logic                          cmd_ack,
  output logic                          push,
  output logic [agc_cmd_pkg::CMD_W-1:0] push_data
);

  agc_cmd_pkg::intake_state_t state, state_nxt;

  // Accept only from idle, and only with room in the FIFO
  assign push      = (state == agc_cmd_pkg::IN_IDLE) && cmd_req && !full;
  assign push_data = {cmd_op, cmd_addr, cmd_data};

  // Ack is high in every state past the push
  assign cmd_ack = (state != agc_cmd_pkg::IN_IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      agc_cmd_pkg::IN_IDLE: begin
        if (push) begin
          state_nxt = agc_cmd_pkg::IN_ACK;
        end
      end
      // First ack cycle, sender may already have let go
      agc_cmd_pkg::IN_ACK: begin
        state_nxt = cmd_req ? agc_cmd_pkg::IN_WAIT_LOW : agc_cmd_pkg::IN_IDLE;
      end
      // Hold ack until req is seen low
      agc_cmd_pkg::IN_WAIT_LOW: begin
        if (!cmd_req) begin
          state_nxt = agc_cmd_pkg::IN_IDLE;
        end
      end
      default: state_nxt = agc_cmd_pkg::IN_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      state <= agc_cmd_pkg::IN_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule
